// ==== rtl/frame_tick.sv ====
`timescale 1ns/1ns

module frame_tick #(
	parameter int FRAME_CYCLES = 833333
) (
	input logic CLOCK_50,
	input logic rst,
	output logic tick
);

	localparam int CW = $clog2(FRAME_CYCLES);

	logic [CW-1:0] count;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			count <= CW'(FRAME_CYCLES - 1);
			tick <= 1'b0;
		end else if (count == '0) begin
			count <= CW'(FRAME_CYCLES - 1); // Reload for next frame
			tick <= 1'b1;
		end else begin
			count <= count - CW'(1);
			tick <= 1'b0;
		end
	end

endmodule

// ==== rtl/seven_seg_decoder.sv ====
`timescale 1ns/1ns

module seven_seg_decoder (
	input logic [3:0] digit,
	output logic [6:0] segments
);

	// Segment on when its bit is low
	always_comb begin
		case (digit)
			4'h0: segments = 7'h40;
			4'h1: segments = 7'h79;
			4'h2: segments = 7'h24;
			4'h3: segments = 7'h30;
			4'h4: segments = 7'h19;
			4'h5: segments = 7'h12;
			4'h6: segments = 7'h02;
			4'h7: segments = 7'h78;
			4'h8: segments = 7'h00;
			4'h9: segments = 7'h18;
			4'hA: segments = 7'h08;
			4'hB: segments = 7'h03;
			4'hC: segments = 7'h46;
			4'hD: segments = 7'h21;
			4'hE: segments = 7'h06;
			default: segments = 7'h0E; // F
		endcase
	end

endmodule

// ==== rtl/sprite_painter.sv ====
`timescale 1ns/1ns

module sprite_painter (
	input logic CLOCK_50,
	input logic rst,
	input logic tick,
	input tank_pkg::player_t player_1,
	input tank_pkg::player_t player_2,
	output logic update_1,
	output logic update_2,
	output tank_pkg::pixel_t pixel
);

	tank_pkg::paint_state_e state;
	tank_pkg::paint_state_e sprite_next;
	logic [15:0] cnt;
	logic cur; // 0 while painting player 1
	logic clear_pending;
	logic drawing;
	tank_pkg::player_t cur_player;
	tank_pkg::pos_t origin;
	logic [15:0] sprite_h;
	logic [15:0] last;

	assign cur_player = cur ? player_2 : player_1;
	assign drawing = state inside {tank_pkg::DRAW_TANK, tank_pkg::DRAW_GUN,
		tank_pkg::DRAW_BULLET};

	// Sprite origin, height and last count of the current state
	always_comb begin
		origin = cur_player.tank;
		sprite_h = 16'(tank_pkg::TANK_H);
		last = 16'(tank_pkg::TANK_W * tank_pkg::TANK_H - 1);
		sprite_next = tank_pkg::IDLE;
		case (state)
			tank_pkg::CLEAR: last = 16'hFFFF;
			tank_pkg::ERASE_TANK: sprite_next = tank_pkg::ERASE_GUN;
			tank_pkg::DRAW_TANK: sprite_next = tank_pkg::DRAW_GUN;
			tank_pkg::ERASE_GUN, tank_pkg::DRAW_GUN: begin
				origin = cur_player.gun;
				sprite_h = 16'(tank_pkg::GUN_H);
				last = 16'(tank_pkg::GUN_W * tank_pkg::GUN_H - 1);
				sprite_next = drawing ? tank_pkg::DRAW_BULLET : tank_pkg::ERASE_BULLET;
			end
			tank_pkg::ERASE_BULLET, tank_pkg::DRAW_BULLET: begin
				origin = cur_player.bullet;
				sprite_h = 16'(tank_pkg::BULLET_H);
				last = 16'(tank_pkg::BULLET_W * tank_pkg::BULLET_H - 1);
				if (!drawing)
					sprite_next = tank_pkg::UPDATE;
				else if (!cur)
					sprite_next = tank_pkg::ERASE_TANK; // On to player 2
			end
			default: sprite_next = tank_pkg::IDLE;
		endcase
	end

	always_comb begin
		pixel.plot = (state != tank_pkg::IDLE) && (state != tank_pkg::UPDATE);
		if (drawing)
			pixel.colour = cur ? tank_pkg::COLOUR_P2 : tank_pkg::COLOUR_P1;
		else
			pixel.colour = tank_pkg::COLOUR_BLACK;
		if (state == tank_pkg::CLEAR) begin
			pixel.x = cnt[7:0];
			pixel.y = cnt[15:8];
		end else begin
			pixel.x = origin.x + tank_pkg::coord_t'(cnt / sprite_h);
			pixel.y = origin.y + tank_pkg::coord_t'(cnt % sprite_h);
		end
	end

	assign update_1 = (state == tank_pkg::UPDATE) && !cur;
	assign update_2 = (state == tank_pkg::UPDATE) && cur;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= tank_pkg::IDLE; // Screen clear starts once reset is gone
			cnt <= '0;
			cur <= 1'b0;
			clear_pending <= 1'b1;
		end else begin
			case (state)
				tank_pkg::IDLE: begin
					if (clear_pending)
						state <= tank_pkg::CLEAR;
					else if (tick)
						state <= tank_pkg::ERASE_TANK;
				end
				tank_pkg::CLEAR: begin
					cnt <= cnt + 16'd1; // Wraps to zero at the end
					if (cnt == last) begin
						state <= tank_pkg::IDLE;
						clear_pending <= 1'b0;
					end
				end
				tank_pkg::UPDATE: state <= tank_pkg::DRAW_TANK;
				default: begin
					if (cnt == last) begin
						cnt <= '0;
						state <= sprite_next;
						if (state == tank_pkg::DRAW_BULLET)
							cur <= ~cur;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
			endcase
		end
	end

endmodule

// ==== rtl/tank_duel.sv ====
`timescale 1ns/1ns

module tank_duel #(
	parameter int FRAME_CYCLES = 833333
) (
	input logic CLOCK_50,
	input logic rst,
	input tank_pkg::pad_t pad_1,
	input tank_pkg::pad_t pad_2,
	output tank_pkg::pixel_t pixel,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);

	logic tick;
	logic update_1;
	logic update_2;
	tank_pkg::player_t player_1;
	tank_pkg::player_t player_2;
	tank_pkg::score_t score_1;
	tank_pkg::score_t score_2;

	frame_tick #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) u_frame_tick (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.tick(tick)
	);

	// Player 1 plays from the right
	tank_player #(
		.SIDE(tank_pkg::RIGHT_SIDE)
	) u_player_1 (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.update(update_1),
		.pad(pad_1),
		.foe_tank(player_2.tank),
		.state(player_1),
		.score(score_1)
	);

	tank_player #(
		.SIDE(tank_pkg::LEFT_SIDE)
	) u_player_2 (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.update(update_2),
		.pad(pad_2),
		.foe_tank(player_1.tank),
		.state(player_2),
		.score(score_2)
	);

	sprite_painter u_painter (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.tick(tick),
		.player_1(player_1),
		.player_2(player_2),
		.update_1(update_1),
		.update_2(update_2),
		.pixel(pixel)
	);

	seven_seg_decoder u_hex4 (.digit(score_1.ones), .segments(hex4));
	seven_seg_decoder u_hex5 (.digit(score_1.tens), .segments(hex5));
	seven_seg_decoder u_hex6 (.digit(score_2.ones), .segments(hex6));
	seven_seg_decoder u_hex7 (.digit(score_2.tens), .segments(hex7));

endmodule

// ==== rtl/tank_pkg.sv ====
package tank_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [2:0] colour_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} pad_t;

	typedef struct packed {
		pos_t tank;
		pos_t gun;
		pos_t bullet;
		logic fired;
	} player_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		colour_t colour;
		logic plot;
	} pixel_t;

	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] ones;
	} score_t;

	typedef enum logic {RIGHT_SIDE, LEFT_SIDE} side_e;

	typedef enum logic [3:0] {
		CLEAR,
		IDLE,
		ERASE_TANK,
		ERASE_GUN,
		ERASE_BULLET,
		UPDATE,
		DRAW_TANK,
		DRAW_GUN,
		DRAW_BULLET
	} paint_state_e;

	localparam colour_t COLOUR_BLACK = 3'd0;
	localparam colour_t COLOUR_P1 = 3'd3;
	localparam colour_t COLOUR_P2 = 3'd1;

	// Sprite sizes in pixels
	localparam int TANK_W = 8;
	localparam int TANK_H = 16;
	localparam int GUN_W = 4;
	localparam int GUN_H = 4;
	localparam int BULLET_W = 4;
	localparam int BULLET_H = 2;

	localparam coord_t RIGHT_START_X = 8'd144;
	localparam coord_t LEFT_START_X = 8'd8;
	localparam coord_t START_Y = 8'd50;
	localparam coord_t GUN_DX = 8'd4;
	localparam coord_t GUN_DY = 8'd3;

	localparam coord_t Y_MIN = 8'd10;
	localparam coord_t Y_MAX = 8'd100;
	localparam coord_t RIGHT_X_MIN = 8'd123;
	localparam coord_t RIGHT_X_MAX = 8'd144;
	localparam coord_t LEFT_X_MIN = 8'd8;
	localparam coord_t LEFT_X_MAX = 8'd30;
	localparam coord_t BULLET_FAR_X = 8'd150; // Reload point of the left bullet

endpackage

// ==== rtl/tank_player.sv ====
`timescale 1ns/1ns

module tank_player #(
	parameter tank_pkg::side_e SIDE = tank_pkg::RIGHT_SIDE
) (
	input logic CLOCK_50,
	input logic rst,
	input logic update,
	input tank_pkg::pad_t pad,
	input tank_pkg::pos_t foe_tank,
	output tank_pkg::player_t state,
	output tank_pkg::score_t score
);

	localparam logic IS_RIGHT = (SIDE == tank_pkg::RIGHT_SIDE);

	localparam tank_pkg::coord_t X_MIN = IS_RIGHT ? tank_pkg::RIGHT_X_MIN
		: tank_pkg::LEFT_X_MIN;
	localparam tank_pkg::coord_t X_MAX = IS_RIGHT ? tank_pkg::RIGHT_X_MAX
		: tank_pkg::LEFT_X_MAX;
	localparam tank_pkg::coord_t START_X = IS_RIGHT ? tank_pkg::RIGHT_START_X
		: tank_pkg::LEFT_START_X;
	localparam tank_pkg::coord_t RELOAD_X = IS_RIGHT ? 8'd0 : tank_pkg::BULLET_FAR_X;
	localparam tank_pkg::pos_t START = {START_X, tank_pkg::START_Y};

	tank_pkg::player_t nxt;
	tank_pkg::score_t nxt_score;
	logic hit;

	// Gun sits on the side of the tank that faces the opponent
	function automatic tank_pkg::pos_t gun_of(input tank_pkg::pos_t tank);
		tank_pkg::pos_t gun;
		gun.y = tank.y + tank_pkg::GUN_DY;
		if (IS_RIGHT)
			gun.x = tank.x - tank_pkg::GUN_DX;
		else
			gun.x = tank.x + tank_pkg::GUN_DX;
		return gun;
	endfunction

	always_comb begin
		nxt = state;
		nxt_score = score;

		// Each limit is checked against the position before this update
		if (pad.up && state.tank.y > tank_pkg::Y_MIN)
			nxt.tank.y = nxt.tank.y - 8'd1;
		if (pad.down && state.tank.y < tank_pkg::Y_MAX)
			nxt.tank.y = nxt.tank.y + 8'd1;
		if (pad.left && state.tank.x > X_MIN)
			nxt.tank.x = nxt.tank.x - 8'd1;
		if (pad.right && state.tank.x < X_MAX)
			nxt.tank.x = nxt.tank.x + 8'd1;
		nxt.gun = gun_of(nxt.tank);

		if (!state.fired) begin
			nxt.bullet = nxt.gun; // Loaded bullet rides on the gun
			nxt.fired = pad.fire;
		end

		if (nxt.fired) begin
			if (nxt.bullet.x == RELOAD_X) begin
				nxt.bullet = nxt.gun;
				nxt.fired = 1'b0;
			end else if (IS_RIGHT) begin
				nxt.bullet.x = nxt.bullet.x - 8'd1;
			end else begin
				nxt.bullet.x = nxt.bullet.x + 8'd1;
			end
		end

		hit = nxt.fired
			&& nxt.bullet.x >= foe_tank.x
			&& nxt.bullet.x <= foe_tank.x + tank_pkg::coord_t'(tank_pkg::TANK_W - 1)
			&& nxt.bullet.y >= foe_tank.y
			&& nxt.bullet.y <= foe_tank.y + tank_pkg::coord_t'(tank_pkg::TANK_H - 1);

		if (hit) begin
			nxt.bullet = nxt.gun;
			nxt.fired = 1'b0;
			if (score.ones == 4'd9) begin
				nxt_score.ones = 4'd0;
				nxt_score.tens = (score.tens == 4'd9) ? 4'd0 : score.tens + 4'd1; // 99 wraps
			end else begin
				nxt_score.ones = score.ones + 4'd1;
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state.tank <= START;
			state.gun <= gun_of(START);
			state.bullet <= gun_of(START);
			state.fired <= 1'b0;
			score <= '0;
		end else if (update) begin
			state <= nxt;
			score <= nxt_score;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tank_duel_tb -f tank_duel.f > sim.log 2>&1 &&
	./obj_dir/Vtank_duel_tb >> sim.log 2>&1
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

// ==== tank_duel.f ====
+incdir+verif
rtl/tank_pkg.sv
rtl/frame_tick.sv
rtl/tank_player.sv
rtl/sprite_painter.sv
rtl/seven_seg_decoder.sv
rtl/tank_duel.sv
verif/tank_duel_tb.sv

// ==== verif/tank_duel_checks.svh ====
`ifndef TANK_DUEL_CHECKS_SVH
`define TANK_DUEL_CHECKS_SVH

int mismatches = 0;
int timeouts = 0;

// Active-low codes of the digits 0 to 9
localparam logic [6:0] SEG_TABLE [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
	7'h12, 7'h02, 7'h78, 7'h00, 7'h18};

function automatic logic [3:0] digit_of(input logic [6:0] seg);
	logic [3:0] d;
	d = 4'hF; // Not a decimal digit
	for (int i = 0; i < 10; i++)
		if (SEG_TABLE[i] == seg)
			d = 4'(i);
	return d;
endfunction

task automatic compare_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH t=%0t %s: got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic compare_pos(input string name, input tank_pkg::pos_t got,
		input tank_pkg::pos_t exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH t=%0t %s: got (%0d,%0d) expected (%0d,%0d)", $time, name,
			got.x, got.y, exp.x, exp.y);
	end
endtask

task automatic compare_score(input string name, input logic [6:0] tens_seg,
		input logic [6:0] ones_seg, input tank_pkg::score_t exp);
	tank_pkg::score_t got;
	got = {digit_of(tens_seg), digit_of(ones_seg)};
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH t=%0t %s: got %h%h expected %h%h", $time, name,
			got.tens, got.ones, exp.tens, exp.ones);
	end
endtask

task automatic compare_pixel(input string name, input tank_pkg::pixel_t got,
		input tank_pkg::pixel_t exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH t=%0t %s: got x=%0d y=%0d c=%0d p=%b expected x=%0d y=%0d c=%0d p=%b",
			$time, name, got.x, got.y, got.colour, got.plot,
			exp.x, exp.y, exp.colour, exp.plot);
	end
endtask

`endif

// ==== verif/tank_duel_tb.sv ====
`timescale 1ns/1ns

module tank_duel_tb;

	localparam int FRAME_CYCLES = 1000;
	localparam int FRAME_TIMEOUT = 3 * FRAME_CYCLES; // Cycles
	localparam int HIT_TIMEOUT = 200; // Frames
	localparam tank_pkg::pad_t NO_KEYS = '0;

	logic CLOCK_50;
	logic rst;
	tank_pkg::pad_t pad_1;
	tank_pkg::pad_t pad_2;
	tank_pkg::pixel_t pixel;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [6:0] hex6;
	logic [6:0] hex7;

	logic [16:0] lfsr = 17'd84001;
	tank_pkg::player_t model_1;
	tank_pkg::player_t model_2;
	tank_pkg::score_t model_score_1;
	tank_pkg::score_t model_score_2;
	int p1_count = 0;
	int p2_count = 0;
	int frames_seen = 0;
	tank_pkg::pos_t tank_1_acc;
	tank_pkg::pos_t tank_2_acc;
	tank_pkg::pos_t gun_1_acc;
	tank_pkg::pos_t bullet_1_acc;
	tank_pkg::pos_t seen_tank_1;
	tank_pkg::pos_t seen_tank_2;
	tank_pkg::pos_t seen_gun_1;
	tank_pkg::pos_t seen_bullet_1;

	`include "tank_duel_checks.svh"

	tank_duel #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) u_dut (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.pad_1(pad_1),
		.pad_2(pad_2),
		.pixel(pixel),
		.hex4(hex4),
		.hex5(hex5),
		.hex6(hex6),
		.hex7(hex7)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	function automatic tank_pkg::pos_t take_min(input tank_pkg::pos_t acc,
			input tank_pkg::pixel_t px, input bit first);
		tank_pkg::pos_t m;
		m = acc;
		if (first || px.x < m.x)
			m.x = px.x;
		if (first || px.y < m.y)
			m.y = px.y;
		return m;
	endfunction

	// Each colour draws 128 tank pixels, then 16 gun and 8 bullet pixels
	always @(negedge CLOCK_50) begin
		if (!rst && pixel.plot === 1'b1) begin
			if (pixel.colour == tank_pkg::COLOUR_P1) begin
				if (p1_count < 128)
					tank_1_acc = take_min(tank_1_acc, pixel, p1_count == 0);
				else if (p1_count < 144)
					gun_1_acc = take_min(gun_1_acc, pixel, p1_count == 128);
				else
					bullet_1_acc = take_min(bullet_1_acc, pixel, p1_count == 144);
				p1_count++;
			end else if (pixel.colour == tank_pkg::COLOUR_P2) begin
				if (p2_count < 128)
					tank_2_acc = take_min(tank_2_acc, pixel, p2_count == 0);
				p2_count++;
				if (p2_count == 152) begin // Last pixel of the frame
					seen_tank_1 = tank_1_acc;
					seen_tank_2 = tank_2_acc;
					seen_gun_1 = gun_1_acc;
					seen_bullet_1 = bullet_1_acc;
					p1_count = 0;
					p2_count = 0;
					frames_seen++;
				end
			end
		end
	end

	// Fibonacci LFSR with taps at bits 17 and 14
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic random_pad(output tank_pkg::pad_t p);
		logic [3:0] bits;
		for (int i = 0; i < 4; i++) begin
			lfsr = lfsr_step(lfsr);
			bits[i] = lfsr[0];
		end
		p = {bits, 1'b0}; // Fire held low
	endtask

	function automatic tank_pkg::score_t bcd_inc(input tank_pkg::score_t s);
		int v;
		tank_pkg::score_t r;
		v = (int'(s.tens) * 10 + int'(s.ones) + 1) % 100;
		r.tens = 4'(v / 10);
		r.ones = 4'(v % 10);
		return r;
	endfunction

	function automatic tank_pkg::pad_t pad_toward(input tank_pkg::coord_t y,
			input tank_pkg::coord_t goal);
		tank_pkg::pad_t p;
		p = '0;
		p.up = (y > goal);
		p.down = (y < goal);
		return p;
	endfunction

	function automatic tank_pkg::score_t shown_score(input bit of_player_1);
		if (of_player_1)
			return {digit_of(hex5), digit_of(hex4)};
		return {digit_of(hex7), digit_of(hex6)};
	endfunction

	task automatic advance_player(input bit right_side, input tank_pkg::pad_t pad,
			input tank_pkg::pos_t foe, inout tank_pkg::player_t p,
			inout tank_pkg::score_t s);
		tank_pkg::pos_t old;
		tank_pkg::coord_t x_lo;
		tank_pkg::coord_t x_hi;
		tank_pkg::coord_t reload_x;
		bit hit;
		old = p.tank;
		x_lo = right_side ? 8'd123 : 8'd8;
		x_hi = right_side ? 8'd144 : 8'd30;
		reload_x = right_side ? 8'd0 : 8'd150;
		if (pad.up && old.y > 8'd10)
			p.tank.y = p.tank.y - 8'd1;
		if (pad.down && old.y < 8'd100)
			p.tank.y = p.tank.y + 8'd1;
		if (pad.left && old.x > x_lo)
			p.tank.x = p.tank.x - 8'd1;
		if (pad.right && old.x < x_hi)
			p.tank.x = p.tank.x + 8'd1;
		p.gun.x = right_side ? p.tank.x - 8'd4 : p.tank.x + 8'd4;
		p.gun.y = p.tank.y + 8'd3;
		if (!p.fired) begin
			p.bullet = p.gun;
			p.fired = pad.fire;
		end
		if (p.fired) begin
			if (p.bullet.x == reload_x) begin
				p.bullet = p.gun;
				p.fired = 1'b0;
			end else if (right_side) begin
				p.bullet.x = p.bullet.x - 8'd1;
			end else begin
				p.bullet.x = p.bullet.x + 8'd1;
			end
		end
		hit = p.fired && p.bullet.x >= foe.x && p.bullet.x <= foe.x + 8'd7
			&& p.bullet.y >= foe.y && p.bullet.y <= foe.y + 8'd15;
		if (hit) begin
			p.bullet = p.gun;
			p.fired = 1'b0;
			s = bcd_inc(s);
		end
	endtask

	task automatic finish_run();
		$display("errors: mismatches=%0d timeouts=%0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	// Holds the pads through one frame, then steps the model and checks both tanks
	task automatic run_frame(input tank_pkg::pad_t p1, input tank_pkg::pad_t p2);
		int start;
		int waited;
		@(posedge CLOCK_50);
		pad_1 <= p1;
		pad_2 <= p2;
		start = frames_seen;
		waited = 0;
		while (frames_seen == start && waited < FRAME_TIMEOUT) begin
			@(posedge CLOCK_50);
			waited++;
		end
		if (frames_seen == start) begin
			timeouts++;
			$display("TIMEOUT at %0t: no frame was drawn within %0d cycles", $time, waited);
			finish_run();
		end else begin
			advance_player(1'b1, p1, model_2.tank, model_1, model_score_1);
			advance_player(1'b0, p2, model_1.tank, model_2, model_score_2);
			compare_pos("tank_1", seen_tank_1, model_1.tank);
			compare_pos("tank_2", seen_tank_2, model_2.tank);
		end
	endtask

	task automatic move_to_y(input tank_pkg::coord_t goal_1, input tank_pkg::coord_t goal_2);
		int frames;
		frames = 0;
		while ((model_1.tank.y != goal_1 || model_2.tank.y != goal_2) && frames < 120) begin
			run_frame(pad_toward(model_1.tank.y, goal_1), pad_toward(model_2.tank.y, goal_2));
			frames++;
		end
	endtask

	task automatic score_hit(input bit by_player_1);
		tank_pkg::pad_t shot;
		tank_pkg::score_t target;
		int frames;
		shot = NO_KEYS;
		shot.fire = 1'b1;
		target = bcd_inc(by_player_1 ? model_score_1 : model_score_2);
		run_frame(by_player_1 ? shot : NO_KEYS, by_player_1 ? NO_KEYS : shot);
		frames = 1;
		while (shown_score(by_player_1) != target && frames < HIT_TIMEOUT) begin
			run_frame(NO_KEYS, NO_KEYS);
			frames++;
		end
		if (shown_score(by_player_1) != target) begin
			timeouts++;
			$display("TIMEOUT at %0t: score did not reach %h within %0d frames",
				$time, target, frames);
			finish_run();
		end else begin
			compare_score("score_1", hex5, hex4, model_score_1);
			compare_score("score_2", hex7, hex6, model_score_2);
		end
	endtask

	task automatic clear_after_reset();
		tank_pkg::pixel_t exp;
		@(posedge CLOCK_50);
		@(negedge CLOCK_50);
		compare_bit("plot in reset", pixel.plot, 1'b0);
		@(posedge CLOCK_50);
		rst <= 1'b0;
		@(negedge CLOCK_50);
		compare_bit("plot after reset", pixel.plot, 1'b0);
		for (int i = 0; i < 65536; i++) begin
			@(negedge CLOCK_50);
			exp = {8'(i), 8'(i >> 8), tank_pkg::COLOUR_BLACK, 1'b1};
			compare_pixel("clear pixel", pixel, exp);
		end
		@(negedge CLOCK_50);
		compare_bit("plot in idle", pixel.plot, 1'b0);
		run_frame(NO_KEYS, NO_KEYS);
		compare_pos("tank_1 start", seen_tank_1, {8'd144, 8'd50});
		compare_pos("tank_2 start", seen_tank_2, {8'd8, 8'd50});
	endtask

	task automatic random_moves();
		tank_pkg::pad_t p1;
		tank_pkg::pad_t p2;
		repeat (40) begin
			random_pad(p1);
			random_pad(p2);
			run_frame(p1, p2);
		end
	endtask

	task automatic movement_limits();
		tank_pkg::pad_t p1;
		tank_pkg::pad_t p2;
		p1 = NO_KEYS;
		p1.up = 1'b1;
		p1.right = 1'b1;
		p2 = NO_KEYS;
		p2.down = 1'b1;
		p2.left = 1'b1;
		repeat (120) run_frame(p1, p2);
		compare_pos("tank_1 limit", seen_tank_1, {8'd144, 8'd10});
		compare_pos("tank_2 limit", seen_tank_2, {8'd8, 8'd100});
	endtask

	task automatic bullet_miss();
		tank_pkg::pad_t shot;
		shot = NO_KEYS;
		shot.fire = 1'b1;
		move_to_y(8'd50, 8'd100);
		run_frame(shot, NO_KEYS);
		repeat (159) run_frame(NO_KEYS, NO_KEYS);
		compare_score("score_1", hex5, hex4, 8'h01);
		compare_score("score_2", hex7, hex6, 8'h01);
		compare_pos("bullet_1", seen_bullet_1, model_1.gun);
		compare_pos("gun_1", seen_gun_1, model_1.gun);
	endtask

	task automatic score_carry();
		int hits;
		hits = 0;
		move_to_y(8'd50, 8'd50);
		while (model_score_1 != 8'h10 && hits < 10) begin
			score_hit(1'b1);
			hits++;
		end
		compare_score("score_1 carry", hex5, hex4, 8'h10);
	endtask

	initial begin
		rst <= 1'b1;
		pad_1 <= NO_KEYS;
		pad_2 <= NO_KEYS;
		model_1.tank = {8'd144, 8'd50};
		model_1.gun = {8'd140, 8'd53};
		model_1.bullet = model_1.gun;
		model_1.fired = 1'b0;
		model_2.tank = {8'd8, 8'd50};
		model_2.gun = {8'd12, 8'd53};
		model_2.bullet = model_2.gun;
		model_2.fired = 1'b0;
		model_score_1 = '0;
		model_score_2 = '0;
		clear_after_reset();
		random_moves();
		movement_limits();
		move_to_y(8'd50, 8'd50);
		score_hit(1'b1);
		score_hit(1'b0);
		bullet_miss();
		score_carry();
		finish_run();
	end

endmodule
